// ==== common/sdram_cfg_pkg.sv ====
package sdram_cfg_pkg;

  // controller side geometry
  localparam int addr_w  = 24;  // word address
  localparam int data_w  = 16;  // one sdram word
  localparam int burst_w = 10;  // burst length field

  typedef logic [addr_w-1:0]  addr_t;
  typedef logic [data_w-1:0]  data_t;
  typedef logic [burst_w-1:0] burst_t;

endpackage

// ==== common/req_pkg.sv ====
package req_pkg;

  // what a requester asks the burst sequencer for
  typedef enum logic [1:0] {
    kind_rd_line   = 2'd0,  // fill of the read line cache
    kind_wr_single = 2'd1,  // one word write
    kind_wr_line   = 2'd2   // streamed line flush
  } req_kind_t;

  localparam int unsigned rd_line_words = 4;   // read cache line
  localparam int unsigned wr_line_words = 16;  // stream buffer line

endpackage

// ==== common/line_if.sv ====
`timescale 1ns/10ps

// one request stage talking to the burst sequencer
interface line_if
  import sdram_cfg_pkg::*, req_pkg::*;
();

  logic      req;     // held until done
  req_kind_t kind;
  addr_t     addr;
  data_t     wdata;   // word at beat, combinational
  burst_t    beat;    // current beat index
  data_t     rdata;
  logic      rvalid;  // rdata carries beat
  logic      done;    // one cycle after last beat

  modport requester (
    output req, kind, addr, wdata,
    input  beat, rdata, rvalid, done
  );

  modport server (
    input  req, kind, addr, wdata,
    output beat, rdata, rvalid, done
  );

endinterface

// ==== src/user_port.sv ====
`timescale 1ns/10ps

module user_port
  import sdram_cfg_pkg::*, req_pkg::*;
#(
  parameter int unsigned rd_words = rd_line_words
) (
  input  logic      clk,
  input  logic      sys_rst_n,
  input  addr_t     address,
  input  data_t     data_in,
  input  logic      read_req,
  input  logic      write_req,
  input  logic      write_en,
  output data_t     data_out,
  output logic      read_ack,
  output logic      write_ack,
  line_if.requester lif
);

  localparam int unsigned off_w = $clog2(rd_words);
  localparam int unsigned tag_w = addr_w - off_w;

  logic             read_req_q;
  logic             write_req_q;
  logic             read_rise;
  logic             write_rise;
  logic             line_valid;
  logic [tag_w-1:0] line_tag;
  data_t            line_mem [rd_words];
  logic [off_w-1:0] word_sel;
  logic             req_q;
  req_kind_t        kind_q;
  addr_t            addr_q;
  data_t            wr_word;

  assign read_rise  = read_req & ~read_req_q;
  assign write_rise = write_req & ~write_req_q;
  assign word_sel   = address[off_w-1:0];

  assign lif.req   = req_q;
  assign lif.kind  = kind_q;
  assign lif.addr  = addr_q;
  assign lif.wdata = wr_word;  // single write has one beat

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      read_req_q  <= 1'b0;
      write_req_q <= 1'b0;
      line_valid  <= 1'b0;
      req_q       <= 1'b0;
      read_ack    <= 1'b0;
      write_ack   <= 1'b0;
      data_out    <= '0;
    end else begin
      read_req_q  <= read_req;
      write_req_q <= write_req;
      write_ack   <= 1'b0;
      if (read_rise) begin
        if (line_valid && line_tag == address[addr_w-1:off_w]) begin
          read_ack <= 1'b1;  // hit, answer next cycle
          data_out <= line_mem[word_sel];
        end else begin
          line_valid <= 1'b0;
          req_q      <= 1'b1;
        end
      end else if (write_rise) begin
        line_valid <= 1'b0;
        req_q      <= 1'b1;
      end else if (lif.done) begin
        req_q <= 1'b0;
        if (kind_q == kind_rd_line) begin
          line_valid <= 1'b1;
          read_ack   <= 1'b1;
          data_out   <= line_mem[word_sel];  // last beat landed a cycle ago
        end else begin
          write_ack <= 1'b1;
        end
      end
      if (write_en)
        line_valid <= 1'b0;  // streamed words may hit the line
      if (!read_req && read_ack) begin
        read_ack <= 1'b0;
        data_out <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (read_rise) begin
      kind_q <= kind_rd_line;
      addr_q <= {address[addr_w-1:off_w], {off_w{1'b0}}};  // line aligned
    end else if (write_rise) begin
      kind_q  <= kind_wr_single;
      addr_q  <= address;
      wr_word <= data_in;
    end
    if (lif.done && kind_q == kind_rd_line)
      line_tag <= addr_q[addr_w-1:off_w];
    if (lif.rvalid)
      line_mem[lif.beat[off_w-1:0]] <= lif.rdata;
  end

  // the client serves one request kind at a time
  a_one_req : assert property (@(posedge clk) disable iff (!sys_rst_n)
    !(read_req && write_req))
    else $error("read_req and write_req high together");

endmodule

// ==== stream_write/stream_buffer.sv ====
`timescale 1ns/10ps

module stream_buffer
  import sdram_cfg_pkg::*, req_pkg::*;
#(
  parameter int unsigned wr_words = wr_line_words
) (
  input  logic      clk,
  input  logic      sys_rst_n,
  input  addr_t     address,
  input  data_t     data_in,
  input  logic      write_latch_address,
  input  logic      write_en,
  line_if.requester lif
);

  localparam int unsigned idx_w = $clog2(wr_words);
  localparam logic [idx_w-1:0] last_idx = idx_w'(wr_words - 1);

  addr_t            wr_addr;   // next stream address
  addr_t            cur_addr;
  logic [idx_w-1:0] cur_idx;
  logic             swap;
  logic             pending;   // back line waits for the sequencer
  addr_t            line_addr;
  data_t            front [wr_words-1];  // last word goes straight to back
  data_t            back  [wr_words];

  assign cur_addr = write_latch_address ? address : wr_addr;
  assign cur_idx  = cur_addr[idx_w-1:0];
  assign swap     = write_en && cur_idx == last_idx;

  assign lif.req   = pending;
  assign lif.kind  = kind_wr_line;
  assign lif.addr  = line_addr;
  assign lif.wdata = back[lif.beat[idx_w-1:0]];

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      wr_addr <= '0;
      pending <= 1'b0;
    end else begin
      if (write_en)
        wr_addr <= cur_addr + 1'b1;
      else if (write_latch_address)
        wr_addr <= address;
      if (lif.done)
        pending <= 1'b0;
      if (swap)
        pending <= 1'b1;  // wins over done in the same cycle
    end
  end

  always_ff @(posedge clk) begin
    if (write_en && !swap)
      front[cur_idx] <= data_in;
    if (swap) begin
      for (int i = 0; i < wr_words - 1; i++) begin
        back[i] <= front[i];
      end
      back[wr_words-1] <= data_in;
      line_addr        <= {cur_addr[addr_w-1:idx_w], {idx_w{1'b0}}};
    end
  end

  // back line must be drained before the next one lands
  a_no_overrun : assert property (@(posedge clk) disable iff (!sys_rst_n)
    swap |-> (!pending || lif.done))
    else $error("stream line swapped while back line pending");

endmodule

// ==== src/burst_sequencer.sv ====
`timescale 1ns/10ps

module burst_sequencer
  import sdram_cfg_pkg::*, req_pkg::*;
#(
  parameter int unsigned rd_words = rd_line_words,
  parameter int unsigned wr_words = wr_line_words
) (
  input  logic   clk,
  input  logic   sys_rst_n,
  line_if.server ulif,
  line_if.server slif,
  output logic   sdram_wr_req,
  input  logic   sdram_wr_ack,
  output addr_t  sdram_wr_addr,
  output burst_t sdram_wr_burst,
  output data_t  sdram_din,
  output logic   sdram_rd_req,
  input  logic   sdram_rd_ack,
  output addr_t  sdram_rd_addr,
  output burst_t sdram_rd_burst,
  input  data_t  sdram_dout,
  input  logic   sdram_init_done
);

  typedef enum logic [1:0] {
    st_idle,
    st_busy,
    st_fin
  } state_t;

  state_t state;
  logic   sel_stream;  // grant went to the stream buffer
  logic   rd_op;
  burst_t beat_cnt;
  burst_t burst_len;
  addr_t  req_addr;
  logic   grant_rd;
  logic   grant_ws;
  logic   grant_wl;
  logic   ack;
  logic   last_beat;

  // fixed priority: read line, single write, line write
  assign grant_rd  = ulif.req && ulif.kind == kind_rd_line;
  assign grant_ws  = ulif.req && ulif.kind == kind_wr_single;
  assign grant_wl  = slif.req;
  assign ack       = rd_op ? sdram_rd_ack : sdram_wr_ack;
  assign last_beat = ack && beat_cnt == burst_len - 1'b1;

  assign sdram_rd_addr  = req_addr;
  assign sdram_wr_addr  = req_addr;
  assign sdram_rd_burst = burst_len;
  assign sdram_wr_burst = burst_len;
  assign sdram_din      = sel_stream ? slif.wdata : ulif.wdata;  // beat data, same cycle

  assign ulif.beat   = beat_cnt;
  assign slif.beat   = beat_cnt;
  assign ulif.rdata  = sdram_dout;
  assign slif.rdata  = sdram_dout;
  assign ulif.rvalid = state == st_busy && rd_op && sdram_rd_ack;
  assign slif.rvalid = 1'b0;  // stream side only writes
  assign ulif.done   = state == st_fin && !sel_stream;
  assign slif.done   = state == st_fin && sel_stream;

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state        <= st_idle;
      sel_stream   <= 1'b0;
      rd_op        <= 1'b0;
      beat_cnt     <= '0;
      sdram_rd_req <= 1'b0;
      sdram_wr_req <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          beat_cnt <= '0;
          if (sdram_init_done && (grant_rd || grant_ws || grant_wl)) begin
            state        <= st_busy;
            rd_op        <= grant_rd;
            sel_stream   <= !(grant_rd || grant_ws);
            sdram_rd_req <= grant_rd;
            sdram_wr_req <= !grant_rd;
          end
        end
        st_busy: begin
          if (ack) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (last_beat) begin
              sdram_rd_req <= 1'b0;  // low right after the last ack
              sdram_wr_req <= 1'b0;
              state        <= st_fin;
            end
          end
        end
        st_fin:  state <= st_idle;  // done pulse, requester drops req
        default: state <= st_idle;
      endcase
    end
  end

  // request fields follow the winner while idle
  always_ff @(posedge clk) begin
    if (state == st_idle) begin
      if (grant_rd) begin
        req_addr  <= ulif.addr;
        burst_len <= burst_t'(rd_words);
      end else if (grant_ws) begin
        req_addr  <= ulif.addr;
        burst_len <= burst_t'(1);
      end else begin
        req_addr  <= slif.addr;
        burst_len <= burst_t'(wr_words);
      end
    end
  end

  a_rd_ack_req : assert property (@(posedge clk) disable iff (!sys_rst_n)
    sdram_rd_ack |-> sdram_rd_req)
    else $error("sdram_rd_ack without sdram_rd_req");

  a_wr_ack_req : assert property (@(posedge clk) disable iff (!sys_rst_n)
    sdram_wr_ack |-> sdram_wr_req)
    else $error("sdram_wr_ack without sdram_wr_req");

endmodule

// ==== src/sdram_frontend.sv ====
`timescale 1ns/10ps

module sdram_frontend
  import sdram_cfg_pkg::*, req_pkg::*;
#(
  parameter int unsigned rd_words = rd_line_words,
  parameter int unsigned wr_words = wr_line_words
) (
  input  logic   clk,
  input  logic   sys_rst_n,
  input  addr_t  address,
  input  data_t  data_in,
  output data_t  data_out,
  input  logic   read_req,
  output logic   read_ack,
  input  logic   write_req,
  output logic   write_ack,
  input  logic   write_latch_address,
  input  logic   write_en,
  output logic   sdram_wr_req,
  input  logic   sdram_wr_ack,
  output addr_t  sdram_wr_addr,
  output burst_t sdram_wr_burst,
  output data_t  sdram_din,
  output logic   sdram_rd_req,
  input  logic   sdram_rd_ack,
  output addr_t  sdram_rd_addr,
  output burst_t sdram_rd_burst,
  input  data_t  sdram_dout,
  input  logic   sdram_init_done,
  output logic   sdram_refresh_block
);

  line_if lif_user ();    // reads and single writes
  line_if lif_stream ();  // streamed line flushes

  assign sdram_refresh_block = write_en;  // no refresh while streaming

  user_port #(
    .rd_words (rd_words)
  ) u_user_port (
    .clk       (clk),
    .sys_rst_n (sys_rst_n),
    .address   (address),
    .data_in   (data_in),
    .read_req  (read_req),
    .write_req (write_req),
    .write_en  (write_en),
    .data_out  (data_out),
    .read_ack  (read_ack),
    .write_ack (write_ack),
    .lif       (lif_user.requester)
  );

  stream_buffer #(
    .wr_words (wr_words)
  ) u_stream_buffer (
    .clk                 (clk),
    .sys_rst_n           (sys_rst_n),
    .address             (address),
    .data_in             (data_in),
    .write_latch_address (write_latch_address),
    .write_en            (write_en),
    .lif                 (lif_stream.requester)
  );

  burst_sequencer #(
    .rd_words (rd_words),
    .wr_words (wr_words)
  ) u_burst_sequencer (
    .clk             (clk),
    .sys_rst_n       (sys_rst_n),
    .ulif            (lif_user.server),
    .slif            (lif_stream.server),
    .sdram_wr_req    (sdram_wr_req),
    .sdram_wr_ack    (sdram_wr_ack),
    .sdram_wr_addr   (sdram_wr_addr),
    .sdram_wr_burst  (sdram_wr_burst),
    .sdram_din       (sdram_din),
    .sdram_rd_req    (sdram_rd_req),
    .sdram_rd_ack    (sdram_rd_ack),
    .sdram_rd_addr   (sdram_rd_addr),
    .sdram_rd_burst  (sdram_rd_burst),
    .sdram_dout      (sdram_dout),
    .sdram_init_done (sdram_init_done)
  );

endmodule

// ==== verif/sdram_ctrl_model.sv ====
`timescale 1ns/10ps

// behavioural burst controller, one request at a time
module sdram_ctrl_model
  import sdram_cfg_pkg::*;
#(
  parameter int          mem_aw      = 12,  // words held by the model
  parameter int          init_cycles = 20,
  parameter logic [31:0] seed_init   = 32'h57fb_af32
) (
  input  logic   clk,
  input  logic   sys_rst_n,
  input  logic   sdram_wr_req,
  output logic   sdram_wr_ack,
  input  addr_t  sdram_wr_addr,
  input  burst_t sdram_wr_burst,
  input  data_t  sdram_din,
  input  logic   sdram_rd_req,
  output logic   sdram_rd_ack,
  input  addr_t  sdram_rd_addr,
  input  burst_t sdram_rd_burst,
  output data_t  sdram_dout,
  output logic   sdram_init_done
);

  typedef enum logic [1:0] {
    m_idle,
    m_wait,
    m_burst
  } mstate_t;

  data_t      mem [1 << mem_aw];
  mstate_t    state;
  integer     seed;
  int         init_cnt;
  logic       is_rd;
  addr_t      base;
  burst_t     len;
  burst_t     cnt;   // beat carried by the current ack
  logic [1:0] dly;

  function automatic data_t fill_word(input int unsigned a);
    return data_t'((a * 32'h9e37) ^ (a >> 5) ^ 32'h3c5a);
  endfunction

  function automatic logic [mem_aw-1:0] slot(input addr_t a);
    return a[mem_aw-1:0];
  endfunction

  initial begin
    seed = seed_init;
    for (int i = 0; i < (1 << mem_aw); i++) begin
      mem[i] = fill_word(i);
    end
  end

  always @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state           <= m_idle;
      sdram_wr_ack    <= 1'b0;
      sdram_rd_ack    <= 1'b0;
      sdram_dout      <= '0;
      sdram_init_done <= 1'b0;
      init_cnt        <= 0;
      cnt             <= '0;
      dly             <= '0;
    end else begin
      if (init_cnt < init_cycles)
        init_cnt <= init_cnt + 1;
      else
        sdram_init_done <= 1'b1;
      case (state)
        m_idle: begin
          if (sdram_rd_req || sdram_wr_req) begin
            is_rd <= sdram_rd_req;
            base  <= sdram_rd_req ? sdram_rd_addr : sdram_wr_addr;
            len   <= sdram_rd_req ? sdram_rd_burst : sdram_wr_burst;
            dly   <= 2'($random(seed));  // 0 to 3 extra cycles
            state <= m_wait;
          end
        end
        m_wait: begin
          if (dly == 2'd0) begin
            cnt          <= '0;
            sdram_rd_ack <= is_rd;
            sdram_wr_ack <= !is_rd;
            sdram_dout   <= mem[slot(base)];
            state        <= m_burst;
          end else begin
            dly <= dly - 2'd1;
          end
        end
        m_burst: begin
          if (!is_rd)
            mem[slot(base + cnt)] <= sdram_din;  // din is the beat of this ack
          if (cnt == len - 1'b1) begin
            sdram_rd_ack <= 1'b0;
            sdram_wr_ack <= 1'b0;
            state        <= m_idle;
          end else begin
            cnt        <= cnt + 1'b1;
            sdram_dout <= mem[slot(base + cnt + 1'b1)];
          end
        end
        default: state <= m_idle;
      endcase
    end
  end

endmodule

// ==== verif/tb_sdram_frontend.sv ====
`timescale 1ns/10ps

module tb_sdram_frontend
  import sdram_cfg_pkg::*;
();

  localparam int          tests       = 5;
  localparam int          test_cycles = 200;
  localparam int          margin      = 100;
  localparam int          mem_aw      = 12;
  localparam logic [31:0] seed_init   = 32'h57fb_af32;

  logic   clk;
  logic   sys_rst_n;
  addr_t  address;
  data_t  data_in;
  data_t  data_out;
  logic   read_req;
  logic   read_ack;
  logic   write_req;
  logic   write_ack;
  logic   write_latch_address;
  logic   write_en;
  logic   sdram_wr_req;
  logic   sdram_wr_ack;
  addr_t  sdram_wr_addr;
  burst_t sdram_wr_burst;
  data_t  sdram_din;
  logic   sdram_rd_req;
  logic   sdram_rd_ack;
  addr_t  sdram_rd_addr;
  burst_t sdram_rd_burst;
  data_t  sdram_dout;
  logic   sdram_init_done;
  logic   sdram_refresh_block;

  integer seed;
  logic   stim_on;
  logic   expect_hit;              // a cached read is running
  logic   wr_req_q = 1'b0;
  logic   rd_req_q = 1'b0;
  addr_t  wr_addr_log [$];
  burst_t wr_len_log [$];
  addr_t  rd_addr_log [$];
  burst_t rd_len_log [$];
  data_t  stream_data [32];

  sdram_frontend uut (.*);

  sdram_ctrl_model #(
    .mem_aw    (mem_aw),
    .seed_init (seed_init)
  ) u_model (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // one entry per controller request
  always @(posedge clk) begin
    wr_req_q <= sdram_wr_req;
    rd_req_q <= sdram_rd_req;
    if (sdram_wr_req && !wr_req_q) begin
      wr_addr_log.push_back(sdram_wr_addr);
      wr_len_log.push_back(sdram_wr_burst);
    end
    if (sdram_rd_req && !rd_req_q) begin
      rd_addr_log.push_back(sdram_rd_addr);
      rd_len_log.push_back(sdram_rd_burst);
    end
  end

  task automatic fail_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("mismatch %s: got %h, expected %h", name, got, exp);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first error");
  endtask

  task automatic fail_plain(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
    assert (got == exp) else fail_mismatch(name, got, exp);
  endtask

  task automatic single_write(input addr_t a, input data_t d);
    @(posedge clk);
    address   <= a;
    data_in   <= d;
    write_req <= 1'b1;
    @(posedge clk);
    while (!write_ack) @(posedge clk);
    write_req <= 1'b0;
    @(posedge clk);
  endtask

  task automatic read_word(input addr_t a, output data_t d);
    @(posedge clk);
    address  <= a;
    read_req <= 1'b1;
    @(posedge clk);
    while (!read_ack) @(posedge clk);
    d = data_out;        // stable with the ack
    read_req <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  task automatic stream_words(input addr_t base);
    @(posedge clk);
    address             <= base;
    write_latch_address <= 1'b1;
    @(posedge clk);
    write_latch_address <= 1'b0;
    for (int i = 0; i < 32; i++) begin
      stream_data[i] = data_t'($random(seed));
      write_en <= 1'b1;
      data_in  <= stream_data[i];
      @(posedge clk);
      write_en <= 1'b0;  // gap leaves room for the line flush
      @(posedge clk);
    end
  endtask

  a_idle_after_reset : assert property (@(posedge clk) disable iff (!sys_rst_n)
    !stim_on |-> !(read_ack || write_ack || sdram_rd_req || sdram_wr_req))
    else fail_plain("an ack or controller request rose before stimulus started");

  a_refresh_block : assert property (@(posedge clk)
    sdram_refresh_block == write_en)
    else fail_mismatch("sdram_refresh_block", sdram_refresh_block, write_en);

  a_hit_no_read : assert property (@(posedge clk) expect_hit |-> !sdram_rd_req)
    else fail_plain("sdram_rd_req went high during a cached read");

  initial begin
    repeat (tests * test_cycles + margin) @(posedge clk);
    fail_plain("watchdog expired before the tests finished");
  end

  initial begin
    data_t wd;
    data_t rd;
    addr_t a;
    addr_t b;
    addr_t base;
    int    n_rd;
    int    n_wr;
    int    idx;
    seed                = seed_init;
    sys_rst_n           = 1'b0;
    address             = '0;
    data_in             = '0;
    read_req            = 1'b0;
    write_req           = 1'b0;
    write_latch_address = 1'b0;
    write_en            = 1'b0;
    stim_on             = 1'b0;
    expect_hit          = 1'b0;
    repeat (10) @(posedge clk);
    sys_rst_n <= 1'b1;
    while (!sdram_init_done) @(posedge clk);
    repeat (4) @(posedge clk);
    stim_on <= 1'b1;

    // single write then read back
    a  = addr_t'($random(seed) & 32'hfff);
    wd = data_t'($random(seed));
    single_write(a, wd);
    check_eq("sdram_wr_burst", wr_len_log[$], 1);
    check_eq("sdram_wr_addr", wr_addr_log[$], a);
    check_eq("model word", u_model.mem[a[mem_aw-1:0]], wd);
    read_word(a, rd);
    check_eq("data_out", rd, wd);
    check_eq("sdram_rd_burst", rd_len_log[$], 4);

    // neighbour in the cached line
    b          = {a[addr_w-1:2], a[1:0] + 2'd1};
    n_rd       = rd_len_log.size();
    expect_hit <= 1'b1;
    read_word(b, rd);
    expect_hit <= 1'b0;
    check_eq("read burst count", rd_len_log.size(), n_rd);
    check_eq("data_out", rd, u_model.mem[b[mem_aw-1:0]]);

    // two streamed lines
    base = addr_t'($random(seed) & 32'hff0);
    n_wr = wr_len_log.size();
    stream_words(base);
    while (wr_len_log.size() < n_wr + 2 || sdram_wr_req) @(posedge clk);
    check_eq("sdram_wr_burst", wr_len_log[n_wr], 16);
    check_eq("sdram_wr_addr", wr_addr_log[n_wr], base);
    check_eq("sdram_wr_burst", wr_len_log[n_wr+1], 16);
    check_eq("sdram_wr_addr", wr_addr_log[n_wr+1], base + 16);
    for (int i = 0; i < 32; i++) begin
      check_eq("model word", u_model.mem[(base[mem_aw-1:0] + i) % (1 << mem_aw)],
               stream_data[i]);
    end
    for (int i = 0; i < 3; i++) begin
      idx = $random(seed) & 31;
      read_word(base + idx, rd);
      check_eq("data_out", rd, stream_data[idx]);
    end

    // write into a cached line, re-read must refill
    b = addr_t'($random(seed) & 32'hffc);
    read_word(b, rd);
    read_word(b, rd);
    n_rd = rd_len_log.size();
    wd   = data_t'($random(seed));
    single_write(b + 2, wd);
    read_word(b + 2, rd);
    check_eq("data_out", rd, wd);
    check_eq("read burst count", rd_len_log.size(), n_rd + 1);
    check_eq("sdram_rd_burst", rd_len_log[$], 4);
    check_eq("sdram_rd_addr", rd_addr_log[$], b);

    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== tb.f ====
common/sdram_cfg_pkg.sv
common/req_pkg.sv
common/line_if.sv
src/user_port.sv
stream_write/stream_buffer.sv
src/burst_sequencer.sv
src/sdram_frontend.sv
verif/sdram_ctrl_model.sv
verif/tb_sdram_frontend.sv

// ==== Makefile ====
SIM  := obj_dir/Vtb_sdram_frontend
SRCS := $(shell grep -v '^+' tb.f)

.PHONY: all run clean

all: run

$(SIM): tb.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f tb.f \
		--top-module tb_sdram_frontend -o Vtb_sdram_frontend

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log
